// ==== all.f ====
source/r5p_pkg.sv
source/r5p_ctl_if.sv
source/r5p_fetch.sv
source/r5p_decode.sv
source/r5p_gpr.sv
source/r5p_alu.sv
source/r5p_lsu.sv
source/r5p_core.sv
sim/r5p_core_tb.sv

// ==== sim/r5p_core_tb.sv ====
`timescale 1ns/10ps

module r5p_core_tb;

  import r5p_pkg::*;

  localparam int WAIT_MAX = 200;  // cycles allowed per store

  logic  clk;
  logic  rst;
  logic  if_req;
  adr_t  if_adr;
  ins_t  if_rdt;
  logic  if_ack;
  logic  ls_req;
  logic  ls_wen;
  adr_t  ls_adr;
  sel_t  ls_sel;
  xlen_t ls_wdt;
  xlen_t ls_rdt;
  logic  ls_ack;

  ins_t   imem [0:255];  // instruction memory, word indexed
  xlen_t  dmem [0:255];  // data memory, word indexed
  integer seed;
  logic   rand_on;       // random ack delays
  int     if_wait;       // cycles left before fetch ack
  int     ls_wait;       // cycles left before data ack

  ins_t  prog [$];       // program under construction
  adr_t  exp_adr [$];    // expected stores, in order
  xlen_t exp_dat [$];
  adr_t  log_adr [$];    // stores seen in this pass
  xlen_t log_dat [$];
  adr_t  ref_adr [$];    // stores of the random pass
  xlen_t ref_dat [$];
  adr_t  fetch_q [$];    // accepted fetch addresses

  r5p_core r5p_core_inst (
    .clk    (clk),
    .rst    (rst),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  //////////////////////////////////////////////////
  // reporting and compares
  //////////////////////////////////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_adr(string name, adr_t got, adr_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_sel(string name, sel_t got, sel_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // bus models and monitor
  //////////////////////////////////////////////////

  function automatic int ack_delay();
    if (!rand_on) return 0;
    return {$random(seed)} % 4;  // 0 to 3 extra cycles
  endfunction

  function automatic xlen_t fill_word(adr_t adr);
    return {adr[15:0], adr[31:16]} ^ 32'h5ac3_96e1;  // unique for every address
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      if_ack  <= 1'b0;
      if_wait <= 0;
    end else if (if_ack) begin
      if_ack  <= 1'b0;          // accepted on this edge
      if_wait <= ack_delay();
    end else if (if_req) begin
      if (if_wait == 0) begin
        if_ack <= 1'b1;
        if_rdt <= imem[if_adr[9:2]];  // data comes with ack
      end else begin
        if_wait <= if_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      ls_ack  <= 1'b0;
      ls_wait <= 0;
    end else if (ls_ack) begin
      ls_ack  <= 1'b0;
      ls_wait <= ack_delay();
      if (ls_wen) dmem[ls_adr[9:2]] <= ls_wdt;  // store lands on accept
    end else if (ls_req) begin
      if (ls_wait == 0) begin
        ls_ack <= 1'b1;
        ls_rdt <= dmem[ls_adr[9:2]];
      end else begin
        ls_wait <= ls_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      if (if_req || ls_req) abort_run("a bus request was high during reset");
    end else begin
      if (if_req && ls_req) abort_run("fetch and data requests were high in the same cycle");
      if (if_req && if_ack) fetch_q.push_back(if_adr);
      if (ls_req && ls_ack && ls_wen) begin
        log_adr.push_back(ls_adr);  // every accepted store
        log_dat.push_back(ls_wdt);
      end
    end
  end

  //////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////

  function automatic ins_t r_type(logic [6:0] f7, rid_t rs2, rid_t rs1, logic [2:0] f3,
                                  rid_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic ins_t i_type(logic [11:0] imm, rid_t rs1, logic [2:0] f3, rid_t rd,
                                  logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic ins_t s_type(logic [11:0] imm, rid_t rs2, rid_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw
  endfunction

  function automatic ins_t b_type(logic [12:0] imm, rid_t rs2, rid_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic ins_t u_type(logic [19:0] imm, rid_t rd);
    return {imm, rd, 7'b0110111};  // lui
  endfunction

  function automatic ins_t j_type(logic [20:0] imm, rid_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic ins_t addi(rid_t rd, rid_t rs1, logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, 7'b0010011);
  endfunction

  function automatic xlen_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic adr_t here_pc();
    return adr_t'(prog.size() * 4);  // address of the next emitted word
  endfunction

  //////////////////////////////////////////////////
  // program and store helpers
  //////////////////////////////////////////////////

  task automatic emit(ins_t w);
    prog.push_back(w);
  endtask

  task automatic expect_store(adr_t a, xlen_t d);
    exp_adr.push_back(a);
    exp_dat.push_back(d);
  endtask

  // reset held 8 cycles, program loaded while the core is held
  task automatic start_core();
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    fetch_q.delete();
    foreach (imem[i]) begin
      imem[i] = (i < prog.size()) ? prog[i] : j_type(21'd0, 5'd0);  // jump to self
    end
    prog.delete();
    repeat (7) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic drain_stores();
    int t;
    while (exp_adr.size() > 0) begin
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!(ls_req && ls_ack && ls_wen) && t < WAIT_MAX);
      if (!(ls_req && ls_ack && ls_wen)) begin
        abort_run("timeout while waiting for a store on the data bus");
      end else begin
        check_adr("ls_adr", ls_adr, exp_adr.pop_front());
        check_sel("ls_sel", ls_sel, '1);  // word access, all bytes
        check_xlen("ls_wdt", ls_wdt, exp_dat.pop_front());
      end
    end
  endtask

  // fetch that followed the first fetch of a branch or jump
  task automatic check_fetch_after(adr_t br, adr_t tgt);
    int idx;
    idx = -1;
    foreach (fetch_q[i]) begin
      if (idx < 0 && fetch_q[i] == br) idx = i;
    end
    if (idx < 0 || idx + 1 >= fetch_q.size())
      abort_run("no fetch was seen after a branch or jump");
    else
      check_adr("if_adr", fetch_q[idx + 1], tgt);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic fetch_order_test();
    emit(addi(5'd1, 5'd0, 12'd5));
    emit(addi(5'd2, 5'd1, 12'd7));
    emit(s_type(12'h1c0, 5'd2, 5'd0));
    expect_store(32'h1c0, 32'd12);
    start_core();
    drain_stores();
    if (fetch_q.size() < 3) abort_run("too few instruction fetches after reset");
    for (int i = 0; i < 3; i++) begin
      check_adr("if_adr", fetch_q[i], PC0 + adr_t'(4 * i));  // straight line
    end
  endtask

  // one operation into x3, then stored to its own slot
  task automatic alu_case(ins_t w, xlen_t exp);
    logic [11:0] off;
    off = 12'h100 + 12'(4 * exp_adr.size());
    emit(w);
    emit(s_type(off, 5'd3, 5'd0));
    expect_store(adr_t'(off), exp);
  endtask

  task automatic alu_test();
    xlen_t a;
    xlen_t b;
    a = (32'h80001 << 12) + sext12(12'h234);  // lui + addi
    b = (32'h12345 << 12) + sext12(12'hff0);
    emit(u_type(20'h80001, 5'd1));
    emit(addi(5'd1, 5'd1, 12'h234));
    emit(u_type(20'h12345, 5'd2));
    emit(addi(5'd2, 5'd2, 12'hff0));
    alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
    alu_case(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
    alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
    alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
    alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
    alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), xlen_t'($signed(a) < $signed(b)));
    alu_case(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd3), xlen_t'($signed(b) < $signed(a)));
    alu_case(addi(5'd3, 5'd1, 12'hfff), a + sext12(12'hfff));
    alu_case(i_type(12'h0f0, 5'd1, 3'b111, 5'd3, 7'b0010011), a & sext12(12'h0f0));
    alu_case(i_type(12'hf00, 5'd2, 3'b110, 5'd3, 7'b0010011), b | sext12(12'hf00));
    alu_case(i_type(12'h7ff, 5'd2, 3'b100, 5'd3, 7'b0010011), b ^ sext12(12'h7ff));
    alu_case(i_type(12'hffb, 5'd1, 3'b010, 5'd3, 7'b0010011),
             xlen_t'($signed(a) < $signed(sext12(12'hffb))));
    alu_case(i_type(12'h005, 5'd2, 3'b010, 5'd3, 7'b0010011), xlen_t'($signed(b) < 5));
    alu_case(u_type(20'hfedcb, 5'd3), 32'hfedc_b000);
    start_core();
    drain_stores();
  endtask

  task automatic load_use_test();
    dmem[8'h80] = 32'h1357_9bdf;  // word at 0x200
    emit(addi(5'd7, 5'd0, 12'h321));
    emit(addi(5'd5, 5'd0, 12'h1f0));
    emit(i_type(12'h010, 5'd5, 3'b010, 5'd6, 7'b0000011));  // lw x6, 16(x5)
    emit(r_type(7'h00, 5'd7, 5'd6, 3'b000, 5'd8));          // uses load at once
    emit(s_type(12'h140, 5'd8, 5'd0));
    expect_store(32'h140, 32'h1357_9bdf + 32'h321);
    emit(i_type(12'h300, 5'd0, 3'b010, 5'd9, 7'b0000011));
    emit(r_type(7'h20, 5'd7, 5'd9, 3'b000, 5'd10));
    emit(s_type(12'h144, 5'd10, 5'd0));
    expect_store(32'h144, fill_word(32'h300) - 32'h321);
    emit(i_type(12'h203, 5'd0, 3'b010, 5'd11, 7'b0000011));  // low bits dropped
    emit(s_type(12'h148, 5'd11, 5'd0));
    expect_store(32'h148, 32'h1357_9bdf);
    start_core();
    drain_stores();
  endtask

  task automatic branch_test();
    adr_t beq_pc;
    adr_t bne_pc;
    emit(addi(5'd1, 5'd0, 12'd7));
    emit(addi(5'd2, 5'd0, 12'd7));
    emit(addi(5'd3, 5'd0, 12'd9));
    beq_pc = here_pc();
    emit(b_type(13'd12, 5'd2, 5'd1, 3'b000));  // beq taken
    emit(addi(5'd10, 5'd0, 12'h0aa));
    emit(s_type(12'h180, 5'd10, 5'd0));
    emit(addi(5'd10, 5'd0, 12'h011));
    emit(s_type(12'h184, 5'd10, 5'd0));
    expect_store(32'h184, 32'h11);
    emit(b_type(13'd12, 5'd3, 5'd1, 3'b000));  // beq not taken
    emit(addi(5'd10, 5'd0, 12'h022));
    emit(s_type(12'h188, 5'd10, 5'd0));
    expect_store(32'h188, 32'h22);
    bne_pc = here_pc();
    emit(b_type(13'd12, 5'd3, 5'd1, 3'b001));  // bne taken
    emit(addi(5'd10, 5'd0, 12'h0bb));
    emit(s_type(12'h18c, 5'd10, 5'd0));
    emit(addi(5'd10, 5'd0, 12'h033));
    emit(s_type(12'h190, 5'd10, 5'd0));
    expect_store(32'h190, 32'h33);
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));   // bne not taken
    emit(addi(5'd10, 5'd0, 12'h044));
    emit(s_type(12'h194, 5'd10, 5'd0));
    expect_store(32'h194, 32'h44);
    emit(addi(5'd4, 5'd0, 12'd3));
    emit(addi(5'd4, 5'd4, 12'hfff));           // count down
    emit(b_type(13'h1ffc, 5'd0, 5'd4, 3'b001)); // back by 4 until zero
    emit(s_type(12'h198, 5'd4, 5'd0));
    expect_store(32'h198, 32'h0);
    start_core();
    drain_stores();
    check_fetch_after(beq_pc, beq_pc + 32'd12);
    check_fetch_after(bne_pc, bne_pc + 32'd12);
  endtask

  task automatic jal_x0_test();
    adr_t jal_pc;
    emit(addi(5'd1, 5'd0, 12'h055));
    jal_pc = here_pc();
    emit(j_type(21'd8, 5'd5));           // skip one, link in x5
    emit(addi(5'd1, 5'd0, 12'h066));
    emit(s_type(12'h1a0, 5'd5, 5'd0));
    expect_store(32'h1a0, jal_pc + 32'd4);
    emit(s_type(12'h1a4, 5'd1, 5'd0));
    expect_store(32'h1a4, 32'h55);
    emit(addi(5'd0, 5'd0, 12'h123));     // x0 keeps zero
    emit(s_type(12'h1a8, 5'd0, 5'd0));
    expect_store(32'h1a8, 32'h0);
    start_core();
    drain_stores();
    check_fetch_after(jal_pc, jal_pc + 32'd8);
  endtask

  task automatic run_tests();
    fetch_order_test();
    alu_test();
    load_use_test();
    branch_test();
    jal_x0_test();
    @(posedge clk);  // monitor has logged the last store by now
  endtask

  task automatic compare_logs();
    if (log_adr.size() != ref_adr.size()) begin
      abort_run("store count differs between random and zero delay runs");
    end else begin
      foreach (ref_adr[i]) begin
        check_adr("ls_adr", log_adr[i], ref_adr[i]);
        check_xlen("ls_wdt", log_dat[i], ref_dat[i]);
      end
    end
  endtask

  initial begin
    rst     = 1'b1;
    if_rdt  = '0;
    if_ack  = 1'b0;
    ls_rdt  = '0;
    ls_ack  = 1'b0;
    seed    = 32'hfd02_1c85;
    rand_on = 1'b1;
    if_wait = 0;
    ls_wait = 0;
    foreach (dmem[i]) begin
      dmem[i] = fill_word(adr_t'(i * 4));
    end
    run_tests();             // random ack delays
    ref_adr = log_adr;
    ref_dat = log_dat;
    log_adr.delete();
    log_dat.delete();
    rand_on = 1'b0;
    run_tests();             // same programs, ack at once
    compare_logs();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== source/r5p_alu.sv ====
`timescale 1ns/10ps

module r5p_alu (
  input  r5p_pkg::alu_op_t op,
  input  r5p_pkg::xlen_t   rs1,
  input  r5p_pkg::xlen_t   rs2,
  output r5p_pkg::xlen_t   rd,   // selected result
  output r5p_pkg::xlen_t   sum,  // adder, load/store address
  output logic             eq    // operands equal, for branches
);

  import r5p_pkg::*;

  logic slt;  // signed less than

  // adder always on, independent of op
  assign sum = rs1 + rs2;

  assign slt = ($signed(rs1) < $signed(rs2));

  assign eq = (rs1 == rs2);

  //////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////

  always_comb begin
    unique case (op)
      ALU_ADD:   rd = sum;
      ALU_SUB:   rd = rs1 - rs2;
      ALU_AND:   rd = rs1 & rs2;
      ALU_OR:    rd = rs1 | rs2;
      ALU_XOR:   rd = rs1 ^ rs2;
      ALU_SLT:   rd = xlen_t'(slt);  // zero extended flag
      ALU_PASS2: rd = rs2;           // LUI
      default:   rd = sum;
    endcase
  end

endmodule

// ==== source/r5p_core.sv ====
`timescale 1ns/10ps

module r5p_core (
  input  logic            clk,
  input  logic            rst,
  // instruction fetch bus
  output logic            if_req,
  output r5p_pkg::adr_t   if_adr,
  input  r5p_pkg::ins_t   if_rdt,
  input  logic            if_ack,
  // load/store bus
  output logic            ls_req,
  output logic            ls_wen,
  output r5p_pkg::adr_t   ls_adr,
  output r5p_pkg::sel_t   ls_sel,
  output r5p_pkg::xlen_t  ls_wdt,
  input  r5p_pkg::xlen_t  ls_rdt,
  input  logic            ls_ack
);

  import r5p_pkg::*;

  ins_t  ins;
  adr_t  pc, pc_inc, pc_imm, pc_nxt;
  logic  exe, retire;
  xlen_t gpr_rs1, gpr_rs2, gpr_rd;
  xlen_t alu_rs2, alu_rd, alu_sum;
  logic  alu_eq;
  xlen_t ls_dat;  // load data for writeback

  r5p_ctl_if ctl ();

  //////////////////////////////////////////////////
  // fetch and decode
  //////////////////////////////////////////////////

  r5p_fetch fetch (
    .clk    (clk),
    .rst    (rst),
    .pc_nxt (pc_nxt),
    .retire (retire),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ins    (ins),
    .pc     (pc),
    .exe    (exe)
  );

  r5p_decode decode (
    .ins (ins),
    .ctl (ctl)
  );

  //////////////////////////////////////////////////
  // execute
  //////////////////////////////////////////////////

  r5p_gpr gpr (
    .clk   (clk),
    .rst   (rst),
    .a_rs1 (ctl.rs1),
    .a_rs2 (ctl.rs2),
    .a_rd  (ctl.rd),
    .e_rd  (ctl.rd_en & retire),  // write only on the retire edge
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  assign alu_rs2 = ctl.a2_imm ? ctl.imm : gpr_rs2;  // operand 2 mux

  r5p_alu alu (
    .op  (ctl.alu_op),
    .rs1 (gpr_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum),
    .eq  (alu_eq)
  );

  r5p_lsu lsu (
    .clk    (clk),
    .rst    (rst),
    .exe    (exe),
    .ctl    (ctl),
    .adr    (alu_sum),
    .wdt    (gpr_rs2),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack),
    .rdt    (ls_dat),
    .retire (retire)
  );

  // writeback mux
  always_comb begin
    unique case (ctl.wb_sel)
      WB_ALU:  gpr_rd = alu_rd;
      WB_MEM:  gpr_rd = ls_dat;
      WB_PCN:  gpr_rd = xlen_t'(pc_inc);  // JAL link
      default: gpr_rd = '0;               // no write
    endcase
  end

  //////////////////////////////////////////////////
  // next pc
  //////////////////////////////////////////////////

  assign pc_inc = pc + adr_t'(4);
  assign pc_imm = pc + adr_t'(ctl.imm);  // branch and jal target

  always_comb begin
    unique case (ctl.pc_sel)
      PC_BRN:  pc_nxt = (alu_eq ^ ctl.brn_ne) ? pc_imm : pc_inc;
      PC_JMP:  pc_nxt = pc_imm;
      default: pc_nxt = pc_inc;
    endcase
  end

  // one instruction in flight, buses never overlap
  a_no_overlap: assert property (
    @(posedge clk) disable iff (rst)
    !(if_req && ls_req)
  );

endmodule

// ==== source/r5p_ctl_if.sv ====
`timescale 1ns/10ps

interface r5p_ctl_if;

  import r5p_pkg::*;

  alu_op_t alu_op;  // alu operation
  logic    a2_imm;  // operand 2 from immediate
  xlen_t   imm;     // selected immediate
  rid_t    rs1;
  rid_t    rs2;
  rid_t    rd;
  logic    rd_en;   // register write
  logic    ls_en;   // memory access
  logic    ls_we;   // store
  wb_sel_t wb_sel;  // writeback source
  pc_sel_t pc_sel;  // next pc source
  logic    brn_ne;  // branch on not equal

  // decoder drives everything
  modport dec (
    output alu_op, a2_imm, imm, rs1, rs2, rd, rd_en,
    output ls_en, ls_we, wb_sel, pc_sel, brn_ne
  );

  // execute side, muxes and gpr
  modport exe (
    input alu_op, a2_imm, imm, rs1, rs2, rd, rd_en, wb_sel, pc_sel, brn_ne
  );

  // load/store unit
  modport lsu (
    input ls_en, ls_we
  );

endinterface

// ==== source/r5p_decode.sv ====
`timescale 1ns/10ps

module r5p_decode (
  input  r5p_pkg::ins_t ins,
  r5p_ctl_if.dec        ctl
);

  import r5p_pkg::*;

  logic [6:0] opc;   // opcode
  logic [2:0] f3;    // funct3
  logic [6:0] f7;    // funct7
  xlen_t      imm_i, imm_s, imm_b, imm_j, imm_u;
  alu_op_t    f3_op; // alu op from funct3
  logic       f3_ok; // funct3 is supported

  assign opc = ins[6:0];
  assign f3  = ins[14:12];
  assign f7  = ins[31:25];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  assign imm_u = {ins[31:12], 12'b0};

  // shared funct3 map for register and immediate forms
  always_comb begin
    f3_ok = 1'b1;
    unique case (f3)
      F3_ADD:  f3_op = ALU_ADD;
      F3_SLT:  f3_op = ALU_SLT;
      F3_XOR:  f3_op = ALU_XOR;
      F3_OR:   f3_op = ALU_OR;
      F3_AND:  f3_op = ALU_AND;
      default: begin
        f3_op = ALU_ADD;
        f3_ok = 1'b0;  // shifts, sltu
      end
    endcase
  end

  always_comb begin
    // defaults give a no-op
    ctl.alu_op = ALU_ADD;
    ctl.a2_imm = 1'b0;
    ctl.imm    = imm_i;
    ctl.rs1    = ins[19:15];
    ctl.rs2    = ins[24:20];
    ctl.rd     = ins[11:7];
    ctl.rd_en  = 1'b0;
    ctl.ls_en  = 1'b0;
    ctl.ls_we  = 1'b0;
    ctl.wb_sel = WB_NONE;
    ctl.pc_sel = PC_INC;
    ctl.brn_ne = 1'b0;
    unique case (opc)
      OP_OP: begin
        ctl.alu_op = (f3 == F3_ADD && f7 == F7_SUB) ? ALU_SUB : f3_op;
        ctl.rd_en  = f3_ok;
        ctl.wb_sel = f3_ok ? WB_ALU : WB_NONE;
      end
      OP_IMM: begin
        ctl.alu_op = f3_op;
        ctl.a2_imm = 1'b1;
        ctl.rd_en  = f3_ok;
        ctl.wb_sel = f3_ok ? WB_ALU : WB_NONE;
      end
      OP_LUI: begin
        ctl.alu_op = ALU_PASS2;
        ctl.a2_imm = 1'b1;
        ctl.imm    = imm_u;
        ctl.rd_en  = 1'b1;
        ctl.wb_sel = WB_ALU;
      end
      OP_LOAD: begin
        ctl.a2_imm = 1'b1;  // address from the adder
        ctl.rd_en  = (f3 == F3_LSW);
        ctl.ls_en  = (f3 == F3_LSW);
        ctl.wb_sel = (f3 == F3_LSW) ? WB_MEM : WB_NONE;
      end
      OP_STORE: begin
        ctl.a2_imm = 1'b1;
        ctl.imm    = imm_s;
        ctl.ls_en  = (f3 == F3_LSW);
        ctl.ls_we  = (f3 == F3_LSW);
      end
      OP_BRANCH: begin
        ctl.imm    = imm_b;
        ctl.pc_sel = (f3 == F3_BEQ || f3 == F3_BNE) ? PC_BRN : PC_INC;
        ctl.brn_ne = (f3 == F3_BNE);
      end
      OP_JAL: begin
        ctl.imm    = imm_j;
        ctl.rd_en  = 1'b1;
        ctl.wb_sel = WB_PCN;  // link pc + 4
        ctl.pc_sel = PC_JMP;
      end
      default: ;  // unsupported, keep the no-op
    endcase
  end

endmodule

// ==== source/r5p_fetch.sv ====
`timescale 1ns/10ps

module r5p_fetch (
  input  logic           clk,
  input  logic           rst,
  input  r5p_pkg::adr_t  pc_nxt,  // pc after current instruction
  input  logic           retire,
  output logic           if_req,
  output r5p_pkg::adr_t  if_adr,
  input  r5p_pkg::ins_t  if_rdt,
  input  logic           if_ack,
  output r5p_pkg::ins_t  ins,     // latched instruction
  output r5p_pkg::adr_t  pc,
  output logic           exe      // instruction in execute
);

  import r5p_pkg::*;

  fetch_state_t state;

  //////////////////////////////////////////////////
  // fetch fsm and program counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= FS_IDLE;
      pc    <= PC0;
    end else begin
      unique case (state)
        FS_IDLE: state <= FS_REQ;  // leave idle right after reset
        FS_REQ: begin
          if (if_ack) state <= FS_EXE;  // instruction arrived
        end
        FS_EXE: begin
          if (retire) begin
            state <= FS_REQ;
            pc    <= pc_nxt;  // pc moves only on retire
          end
        end
        default: state <= FS_IDLE;
      endcase
    end
  end

  assign if_req = (state == FS_REQ);
  assign if_adr = pc;  // stable for the whole request
  assign exe    = (state == FS_EXE);

  // instruction register, loaded on the accepting ack
  always_ff @(posedge clk) begin
    if (if_req && if_ack) ins <= if_rdt;
  end

  // stalled request keeps its address
  a_if_hold: assert property (
    @(posedge clk) disable iff (rst)
    (if_req && !if_ack) |=> (if_req && $stable(if_adr))
  );

endmodule

// ==== source/r5p_gpr.sv ====
`timescale 1ns/10ps

module r5p_gpr (
  input  logic            clk,
  input  logic            rst,
  input  r5p_pkg::rid_t   a_rs1,
  input  r5p_pkg::rid_t   a_rs2,
  input  r5p_pkg::rid_t   a_rd,
  input  logic            e_rd,   // write enable, already qualified by retire
  input  r5p_pkg::xlen_t  d_rd,
  output r5p_pkg::xlen_t  d_rs1,
  output r5p_pkg::xlen_t  d_rs2
);

  import r5p_pkg::*;

  xlen_t gpr [0:2**RW-1];

  // synchronous write port
  // x0 is cleared by reset and never written, so it reads zero
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 2**RW; i++) begin
        gpr[i] <= '0;
      end
    end else if (e_rd && (a_rd != '0)) begin
      gpr[a_rd] <= d_rd;
    end
  end

  // combinational read ports
  assign d_rs1 = gpr[a_rs1];
  assign d_rs2 = gpr[a_rs2];

endmodule

// ==== source/r5p_lsu.sv ====
`timescale 1ns/10ps

module r5p_lsu (
  input  logic            clk,
  input  logic            rst,
  input  logic            exe,     // instruction in execute
  r5p_ctl_if.lsu          ctl,
  input  r5p_pkg::xlen_t  adr,     // from the alu adder
  input  r5p_pkg::xlen_t  wdt,     // rs2 value
  output logic            ls_req,
  output logic            ls_wen,
  output r5p_pkg::adr_t   ls_adr,
  output r5p_pkg::sel_t   ls_sel,
  output r5p_pkg::xlen_t  ls_wdt,
  input  r5p_pkg::xlen_t  ls_rdt,
  input  logic            ls_ack,
  output r5p_pkg::xlen_t  rdt,     // load writeback data
  output logic            retire
);

  import r5p_pkg::*;

  //////////////////////////////////////////////////
  // data bus
  //////////////////////////////////////////////////

  assign ls_req = exe & ctl.ls_en;  // held until ack ends execute
  assign ls_wen = ctl.ls_we;

  // word access only, low address bits dropped
  assign ls_adr = adr_t'({adr[XW-1:2], 2'b00});
  assign ls_sel = '1;
  assign ls_wdt = wdt;

  // read data is valid with the ack
  assign rdt = ls_rdt;

  // non-memory retires at once, memory waits for ack
  assign retire = exe & (~ctl.ls_en | ls_ack);

  // stalled transfer keeps every bus output
  a_ls_hold: assert property (
    @(posedge clk) disable iff (rst)
    (ls_req && !ls_ack) |=>
      (ls_req && $stable(ls_wen) && $stable(ls_adr) &&
       $stable(ls_sel) && $stable(ls_wdt))
  );

endmodule

// ==== source/r5p_pkg.sv ====
package r5p_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned XW = 32;  // register and data width
  localparam int unsigned AW = 32;  // bus address width
  localparam int unsigned RW = 5;   // register index width

  typedef logic [XW-1:0]   xlen_t;  // register or data value
  typedef logic [AW-1:0]   adr_t;   // bus address
  typedef logic [32-1:0]   ins_t;   // instruction word
  typedef logic [RW-1:0]   rid_t;   // register index
  typedef logic [XW/8-1:0] sel_t;   // byte select

  localparam adr_t PC0 = '0;  // reset pc

  //////////////////////////////////////////////////
  // opcodes and function fields
  //////////////////////////////////////////////////

  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000;  // also SUB
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_LSW = 3'b010;  // word load/store
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_SUB = 7'b0100000;

  //////////////////////////////////////////////////
  // control encodings
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_PASS2  // operand 2 through, for LUI
  } alu_op_t;

  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PCN} wb_sel_t;

  typedef enum logic [1:0] {PC_INC, PC_BRN, PC_JMP} pc_sel_t;

  typedef enum logic [1:0] {FS_IDLE, FS_REQ, FS_EXE} fetch_state_t;

endpackage
